// File: rtl/mem_defs.svh
/* Memory controller constants */
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// System bus address
`define MEM_ADDR_W 24

// Top two address bits select DRAM, ROM or I/O
`define MEM_REGION_MSB 23
`define MEM_REGION_LSB 22

// DRAM row field for page hit compare
`define MEM_ROW_MSB 21
`define MEM_ROW_LSB 10

`define MEM_LANES 4
`define MEM_SPEED_W 2
`define MEM_WAIT_W 4

// ROM wait cycles, slowest setting first
`define ROM_WAIT_S0 7
`define ROM_WAIT_S1 5
`define ROM_WAIT_S2 3
`define ROM_WAIT_S3 2

// I/O wait cycles, slowest setting first
`define IO_WAIT_S0 15
`define IO_WAIT_S1 7
`define IO_WAIT_S2 3
`define IO_WAIT_S3 1

`endif

// File: rtl/mem_pkg.sv
/* Memory controller types */
package mem_pkg;

	// Target of a transfer, from the top address bits
	typedef enum logic [1:0] {
		region_dram,
		region_rom,
		region_io
	} region_t;

	// Cycle sequencer states
	typedef enum logic [2:0] {
		seq_idle,
		seq_dram,
		seq_wait,
		seq_refresh,
		seq_done
	} seq_state_t;

	// Transfer size as driven by a master
	typedef enum logic [1:0] {
		size_byte = 2'b00,
		size_half = 2'b01,
		size_word = 2'b10
	} xfer_size_t;

endpackage

// File: rtl/bus_arbiter.sv
/* Fixed-priority bus arbiter */
`timescale 1ns/1ps
`include "mem_defs.svh"

module bus_arbiter (
	input  logic                   sys_clk,
	input  logic                   resetl,
	input  logic                   refresh_req,
	input  logic                   m0_req,
	input  logic                   m0_write,
	input  logic [`MEM_ADDR_W-1:0] m0_addr,
	input  mem_pkg::xfer_size_t    m0_size,
	input  logic                   m1_req,
	input  logic                   m1_write,
	input  logic [`MEM_ADDR_W-1:0] m1_addr,
	input  mem_pkg::xfer_size_t    m1_size,
	input  logic                   cyc_done,
	output logic                   m0_gnt,
	output logic                   m1_gnt,
	output logic                   cyc_valid,
	output logic                   cyc_refresh,
	output logic                   cyc_write,
	output logic [`MEM_ADDR_W-1:0] cyc_addr,
	output mem_pkg::xfer_size_t    cyc_size
);

	// One-hot bus owner
	logic own_ref;
	logic own_m0;
	logic own_m1;
	// Dead cycle after a release
	logic settle;
	logic arb_open;

	// Requests are only looked at with the bus free and settled
	assign arb_open = ~(own_ref | own_m0 | own_m1) & ~settle;

	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			own_ref <= 1'b0;
			own_m0 <= 1'b0;
			own_m1 <= 1'b0;
			settle <= 1'b0;
		end else if (cyc_done) begin
			// Grant drops the cycle after ack
			own_ref <= 1'b0;
			own_m0 <= 1'b0;
			own_m1 <= 1'b0;
			settle <= 1'b1;
		end else begin
			settle <= 1'b0;
			if (arb_open) begin
				// Refresh first, then m0, then m1
				own_ref <= refresh_req;
				own_m0 <= ~refresh_req & m0_req;
				own_m1 <= ~refresh_req & ~m0_req & m1_req;
			end
		end
	end

	assign m0_gnt = own_m0;
	assign m1_gnt = own_m1;
	assign cyc_valid = own_ref | own_m0 | own_m1;
	assign cyc_refresh = own_ref;

	// Owner's attributes onto the shared bus
	always_comb begin
		cyc_write = 1'b0;
		cyc_addr = '0;
		cyc_size = mem_pkg::size_byte;
		if (own_m0) begin
			cyc_write = m0_write;
			cyc_addr = m0_addr;
			cyc_size = m0_size;
		end else if (own_m1) begin
			cyc_write = m1_write;
			cyc_addr = m1_addr;
			cyc_size = m1_size;
		end
	end

endmodule

// File: rtl/cycle_sequencer.sv
/* Memory cycle sequencer */
`timescale 1ns/1ps
`include "mem_defs.svh"

module cycle_sequencer (
	input  logic                   sys_clk,
	input  logic                   resetl,
	input  logic                   cyc_valid,
	input  logic                   cyc_refresh,
	input  logic                   cyc_write,
	input  logic [`MEM_ADDR_W-1:0] cyc_addr,
	input  logic                   dram_done,
	input  logic                   wait_done,
	output logic                   cyc_done,
	output logic                   ack,
	output logic                   refresh_ack,
	output logic                   dram_start,
	output logic                   dram_refresh,
	output logic [`MEM_ADDR_W-1:0] dram_addr,
	output logic                   rom_start,
	output logic                   io_start,
	output logic                   rom_cs_l,
	output logic                   io_cs_l,
	output logic                   lane_strobe
);

	mem_pkg::seq_state_t state;
	mem_pkg::seq_state_t next_state;
	mem_pkg::region_t region;
	// Region and kind of the cycle in flight
	mem_pkg::region_t region_q;
	logic refresh_q;
	logic launch;
	logic cs_window;

	// Address decode, 00 and 01 both map to DRAM
	always_comb begin
		case (cyc_addr[`MEM_REGION_MSB:`MEM_REGION_LSB])
			2'b10: region = mem_pkg::region_rom;
			2'b11: region = mem_pkg::region_io;
			default: region = mem_pkg::region_dram;
		endcase
	end

	// Sequencer only idles between cycles, so valid here is a new one
	assign launch = (state == mem_pkg::seq_idle) & cyc_valid;

	// Start pulses go out in the first grant cycle
	assign dram_start = launch & (cyc_refresh | (region == mem_pkg::region_dram));
	assign dram_refresh = cyc_refresh;
	assign dram_addr = cyc_addr;
	assign rom_start = launch & ~cyc_refresh & (region == mem_pkg::region_rom);
	assign io_start = launch & ~cyc_refresh & (region == mem_pkg::region_io);

	always_comb begin
		next_state = state;
		case (state)
			mem_pkg::seq_idle: begin
				if (cyc_valid) begin
					if (cyc_refresh)
						next_state = mem_pkg::seq_refresh;
					else if (region == mem_pkg::region_dram)
						next_state = mem_pkg::seq_dram;
					else
						next_state = mem_pkg::seq_wait;
				end
			end
			mem_pkg::seq_dram, mem_pkg::seq_refresh: begin
				if (dram_done)
					next_state = mem_pkg::seq_done;
			end
			mem_pkg::seq_wait: begin
				if (wait_done)
					next_state = mem_pkg::seq_done;
			end
			default: next_state = mem_pkg::seq_idle;
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			state <= mem_pkg::seq_idle;
			region_q <= mem_pkg::region_dram;
			refresh_q <= 1'b0;
		end else begin
			state <= next_state;
			if (launch) begin
				refresh_q <= cyc_refresh;
				// Refresh counts as DRAM so no chip select fires
				region_q <= cyc_refresh ? mem_pkg::region_dram : region;
			end
		end
	end

	// Done state is the ack cycle
	assign cyc_done = (state == mem_pkg::seq_done);
	assign ack = cyc_done & ~refresh_q;
	assign refresh_ack = cyc_done & refresh_q;

	// ROM is read only, no write strobes towards it
	assign lane_strobe = ack & ~(cyc_write & (region_q == mem_pkg::region_rom));

	// Selects span cycle 1 through ack
	assign cs_window = (state == mem_pkg::seq_wait) | (state == mem_pkg::seq_done);
	assign rom_cs_l = ~(cs_window & (region_q == mem_pkg::region_rom));
	assign io_cs_l = ~(cs_window & (region_q == mem_pkg::region_io));

endmodule

// File: rtl/dram_timing.sv
/* DRAM strobe timing */
`timescale 1ns/1ps
`include "mem_defs.svh"

module dram_timing (
	input  logic                    sys_clk,
	input  logic                    resetl,
	input  logic                    dram_start,
	input  logic                    dram_refresh,
	input  logic [`MEM_ADDR_W-1:0]  dram_addr,
	input  logic [`MEM_SPEED_W-1:0] dram_speed,
	output logic                    dram_done,
	output logic                    ras_l,
	output logic                    cas_l,
	output logic                    row_mux
);

	// Phases of one DRAM cycle
	typedef enum logic [2:0] {
		dt_idle,
		dt_pre,
		dt_row,
		dt_ref,
		dt_col
	} dt_state_t;

	dt_state_t state;
	// Cycles left in the current phase
	logic [`MEM_SPEED_W-1:0] phase_cnt;
	logic phase_end;
	logic refresh_q;
	// Open page
	logic row_valid;
	logic [`MEM_ROW_MSB-`MEM_ROW_LSB:0] open_row;
	logic row_hit;

	assign row_hit = row_valid & (dram_addr[`MEM_ROW_MSB:`MEM_ROW_LSB] == open_row);
	assign phase_end = (phase_cnt == '0);

	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			state <= dt_idle;
			phase_cnt <= '0;
			refresh_q <= 1'b0;
			row_valid <= 1'b0;
			cas_l <= 1'b1;
		end else begin
			// CAS trails the column phase by one cycle of address setup
			cas_l <= (state != dt_col);
			case (state)
				dt_idle: begin
					if (dram_start) begin
						refresh_q <= dram_refresh;
						phase_cnt <= dram_speed;
						if (!dram_refresh && row_hit) begin
							// Page hit, column phase right away
							state <= dt_col;
						end else begin
							// Miss or refresh, close the row first
							row_valid <= 1'b0;
							state <= dt_pre;
						end
					end
				end
				dt_pre: begin
					if (!phase_end) begin
						phase_cnt <= phase_cnt - 1'b1;
					end else if (refresh_q) begin
						phase_cnt <= dram_speed;
						state <= dt_ref;
					end else begin
						// One cycle of row address ahead of RAS
						phase_cnt <= '0;
						state <= dt_row;
					end
				end
				dt_row: begin
					// RAS falls here and the page opens
					row_valid <= 1'b1;
					phase_cnt <= dram_speed;
					state <= dt_col;
				end
				dt_ref, dt_col: begin
					if (phase_end)
						state <= dt_idle;
					else
						phase_cnt <= phase_cnt - 1'b1;
				end
				default: state <= dt_idle;
			endcase
		end
	end

	// Row latched as RAS goes low
	always_ff @(posedge sys_clk) begin
		if (state == dt_row)
			open_row <= dram_addr[`MEM_ROW_MSB:`MEM_ROW_LSB];
	end

	assign dram_done = phase_end & ((state == dt_col) | (state == dt_ref));
	// RAS held low while a page is open, and pulsed for refresh
	assign ras_l = ~(row_valid | (state == dt_ref));
	assign row_mux = (state == dt_row);

endmodule

// File: rtl/wait_counter.sv
/* ROM and I/O wait states */
`timescale 1ns/1ps
`include "mem_defs.svh"

module wait_counter (
	input  logic                    sys_clk,
	input  logic                    resetl,
	input  logic                    rom_start,
	input  logic                    io_start,
	input  logic [`MEM_SPEED_W-1:0] rom_speed,
	input  logic [`MEM_SPEED_W-1:0] io_speed,
	input  logic                    io_wait_l,
	output logic                    wait_done
);

	logic [`MEM_WAIT_W-1:0] count;
	logic [`MEM_WAIT_W-1:0] rom_entry;
	logic [`MEM_WAIT_W-1:0] io_entry;
	logic active;
	logic io_mode;

	// Wait tables, speed 0 slowest
	always_comb begin
		case (rom_speed)
			2'd0: rom_entry = `MEM_WAIT_W'(`ROM_WAIT_S0);
			2'd1: rom_entry = `MEM_WAIT_W'(`ROM_WAIT_S1);
			2'd2: rom_entry = `MEM_WAIT_W'(`ROM_WAIT_S2);
			default: rom_entry = `MEM_WAIT_W'(`ROM_WAIT_S3);
		endcase
		case (io_speed)
			2'd0: io_entry = `MEM_WAIT_W'(`IO_WAIT_S0);
			2'd1: io_entry = `MEM_WAIT_W'(`IO_WAIT_S1);
			2'd2: io_entry = `MEM_WAIT_W'(`IO_WAIT_S2);
			default: io_entry = `MEM_WAIT_W'(`IO_WAIT_S3);
		endcase
	end

	// External wait only stretches I/O once the count runs out
	assign wait_done = active & (count == '0) & (io_wait_l | ~io_mode);

	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			active <= 1'b0;
			io_mode <= 1'b0;
			count <= '0;
		end else if (rom_start | io_start) begin
			active <= 1'b1;
			io_mode <= io_start;
			// Start cycle is the first wait cycle
			count <= io_start ? io_entry - 1'b1 : rom_entry - 1'b1;
		end else if (wait_done) begin
			active <= 1'b0;
		end else if (active && count != '0) begin
			count <= count - 1'b1;
		end
	end

endmodule

// File: rtl/byte_lanes.sv
/* Byte lane strobes */
`timescale 1ns/1ps
`include "mem_defs.svh"

module byte_lanes (
	input  logic                  lane_strobe,
	input  logic                  cyc_write,
	input  logic [1:0]            cyc_addr,
	input  mem_pkg::xfer_size_t   cyc_size,
	output logic [`MEM_LANES-1:0] we_l,
	output logic                  oe_l
);

	// Active-high lanes touched by the transfer
	logic [`MEM_LANES-1:0] lane_mask;

	always_comb begin
		case (cyc_size)
			mem_pkg::size_byte: begin
				// Single lane picked by A1:A0
				lane_mask = `MEM_LANES'(1) << cyc_addr;
			end
			mem_pkg::size_half: begin
				// A1 picks the upper or lower pair
				if (cyc_addr[1])
					lane_mask = 4'b1100;
				else
					lane_mask = 4'b0011;
			end
			default: begin
				lane_mask = '1;
			end
		endcase
	end

	// Write enables for writes, output enable for reads
	assign we_l = (lane_strobe & cyc_write) ? ~lane_mask : '1;
	assign oe_l = ~(lane_strobe & ~cyc_write);

endmodule

// File: rtl/mem_ctrl.sv
/* Memory cycle controller */
`timescale 1ns/1ps
`include "mem_defs.svh"

module mem_ctrl (
	input  logic                    sys_clk,
	input  logic                    resetl,
	input  logic                    refresh_req,
	input  logic                    m0_req,
	input  logic                    m0_write,
	input  logic [`MEM_ADDR_W-1:0]  m0_addr,
	input  mem_pkg::xfer_size_t     m0_size,
	input  logic                    m1_req,
	input  logic                    m1_write,
	input  logic [`MEM_ADDR_W-1:0]  m1_addr,
	input  mem_pkg::xfer_size_t     m1_size,
	input  logic [`MEM_SPEED_W-1:0] dram_speed,
	input  logic [`MEM_SPEED_W-1:0] rom_speed,
	input  logic [`MEM_SPEED_W-1:0] io_speed,
	input  logic                    io_wait_l,
	output logic                    m0_gnt,
	output logic                    m1_gnt,
	output logic                    ack,
	output logic                    refresh_ack,
	output logic                    ras_l,
	output logic                    cas_l,
	output logic                    row_mux,
	output logic                    rom_cs_l,
	output logic                    io_cs_l,
	output logic [`MEM_LANES-1:0]   we_l,
	output logic                    oe_l
);

	// Shared bus from the arbiter
	logic cyc_valid;
	logic cyc_refresh;
	logic cyc_write;
	logic [`MEM_ADDR_W-1:0] cyc_addr;
	mem_pkg::xfer_size_t cyc_size;
	logic cyc_done;

	// Sequencer to timing peers
	logic dram_start;
	logic dram_refresh;
	logic [`MEM_ADDR_W-1:0] dram_addr;
	logic dram_done;
	logic rom_start;
	logic io_start;
	logic wait_done;
	logic lane_strobe;

	bus_arbiter u_arbiter (
		.sys_clk, .resetl, .refresh_req,
		.m0_req, .m0_write, .m0_addr, .m0_size,
		.m1_req, .m1_write, .m1_addr, .m1_size,
		.cyc_done, .m0_gnt, .m1_gnt,
		.cyc_valid, .cyc_refresh, .cyc_write, .cyc_addr, .cyc_size
	);

	cycle_sequencer u_sequencer (
		.sys_clk, .resetl,
		.cyc_valid, .cyc_refresh, .cyc_write, .cyc_addr,
		.dram_done, .wait_done,
		.cyc_done, .ack, .refresh_ack,
		.dram_start, .dram_refresh, .dram_addr,
		.rom_start, .io_start, .rom_cs_l, .io_cs_l, .lane_strobe
	);

	// RAS/CAS and open page
	dram_timing u_dram (
		.sys_clk, .resetl,
		.dram_start, .dram_refresh, .dram_addr, .dram_speed,
		.dram_done, .ras_l, .cas_l, .row_mux
	);

	// ROM and I/O wait states
	wait_counter u_wait (
		.sys_clk, .resetl,
		.rom_start, .io_start, .rom_speed, .io_speed, .io_wait_l,
		.wait_done
	);

	byte_lanes u_lanes (
		.lane_strobe,
		.cyc_write,
		.cyc_addr(cyc_addr[1:0]),
		.cyc_size,
		.we_l,
		.oe_l
	);

endmodule

// File: test/mem_ctrl_tb.sv
/* Memory controller testbench */
`timescale 1ns/1ps
`include "mem_defs.svh"

module mem_ctrl_tb;

	// Target codes for the checks at ack
	localparam int tgt_dram = 0;
	localparam int tgt_rom = 1;
	localparam int tgt_io = 2;

	logic sys_clk;
	logic resetl;
	logic refresh_req;
	logic m0_req;
	logic m0_write;
	logic [`MEM_ADDR_W-1:0] m0_addr;
	mem_pkg::xfer_size_t m0_size;
	logic m1_req;
	logic m1_write;
	logic [`MEM_ADDR_W-1:0] m1_addr;
	mem_pkg::xfer_size_t m1_size;
	logic [`MEM_SPEED_W-1:0] dram_speed;
	logic [`MEM_SPEED_W-1:0] rom_speed;
	logic [`MEM_SPEED_W-1:0] io_speed;
	logic io_wait_l;
	logic m0_gnt;
	logic m1_gnt;
	logic ack;
	logic refresh_ack;
	logic ras_l;
	logic cas_l;
	logic row_mux;
	logic rom_cs_l;
	logic io_cs_l;
	logic [`MEM_LANES-1:0] we_l;
	logic oe_l;

	int errors;
	int checks;
	// Last DRAM address, its row stays open
	logic [`MEM_ADDR_W-1:0] last_dram_addr;
	// row_mux seen high while waiting for the last ack
	logic row_seen;

	mem_ctrl uut (
		.sys_clk, .resetl, .refresh_req,
		.m0_req, .m0_write, .m0_addr, .m0_size,
		.m1_req, .m1_write, .m1_addr, .m1_size,
		.dram_speed, .rom_speed, .io_speed, .io_wait_l,
		.m0_gnt, .m1_gnt, .ack, .refresh_ack,
		.ras_l, .cas_l, .row_mux, .rom_cs_l, .io_cs_l, .we_l, .oe_l
	);

	always #2 sys_clk = ~sys_clk;

	// Wait-state tables, speed 0 slowest
	function automatic int rom_wait(input int speed);
		case (speed)
			0: return `ROM_WAIT_S0;
			1: return `ROM_WAIT_S1;
			2: return `ROM_WAIT_S2;
			default: return `ROM_WAIT_S3;
		endcase
	endfunction

	function automatic int io_wait(input int speed);
		case (speed)
			0: return `IO_WAIT_S0;
			1: return `IO_WAIT_S1;
			2: return `IO_WAIT_S2;
			default: return `IO_WAIT_S3;
		endcase
	endfunction

	// Page hit skips precharge and row phases
	function automatic int dram_latency(input logic hit, input int speed);
		if (hit)
			return speed + 2;
		return 2 * speed + 4;
	endfunction

	// Lanes touched, one bit per byte lane
	function automatic logic [3:0] lane_mask(input mem_pkg::xfer_size_t size,
		input logic [1:0] lo);
		logic [3:0] mask;
		mask = 4'b0000;
		for (int i = 0; i < 4; i++) begin
			if (size == mem_pkg::size_word)
				mask[i] = 1'b1;
			else if (size == mem_pkg::size_half)
				mask[i] = ((i / 2) == lo[1]);
			else
				mask[i] = (i == lo);
		end
		return mask;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic report_timeout(input string what);
		errors++;
		$display("Timed out at %0t ns waiting for %s", $time, what);
	endtask

	// Caller sits on a rising edge, so these are NBA drives
	task automatic set_request(input int master, input logic write,
		input logic [`MEM_ADDR_W-1:0] addr, input mem_pkg::xfer_size_t size);
		if (master == 0) begin
			m0_req <= 1'b1;
			m0_write <= write;
			m0_addr <= addr;
			m0_size <= size;
		end else begin
			m1_req <= 1'b1;
			m1_write <= write;
			m1_addr <= addr;
			m1_size <= size;
		end
	endtask

	task automatic drop_request(input int master);
		if (master == 0)
			m0_req <= 1'b0;
		else
			m1_req <= 1'b0;
	endtask

	// Returns on the falling edge of cycle 0
	task automatic wait_grant(input int master, output logic ok);
		int count;
		ok = 1'b0;
		count = 0;
		while (!ok && count < 64) begin
			@(negedge sys_clk);
			count++;
			ok = (master == 0) ? m0_gnt : m1_gnt;
		end
		if (!ok)
			report_timeout(master == 0 ? "m0_gnt" : "m1_gnt");
	endtask

	// Counts cycles to ack, io_wait_l goes high after cycle release_n
	task automatic wait_ack(input int target, input int exp_n, input int release_n,
		input logic write, input mem_pkg::xfer_size_t size, input logic [1:0] lo);
		int n;
		logic [3:0] exp_we;
		n = 0;
		row_seen = 1'b0;
		while (!ack && n < 80) begin
			@(posedge sys_clk);
			if (n == release_n)
				io_wait_l <= 1'b1;
			@(negedge sys_clk);
			n++;
			if (row_mux)
				row_seen = 1'b1;
		end
		if (!ack) begin
			report_timeout("ack");
		end else begin
			check_value("ack latency", n, exp_n);
			check_value("refresh_ack", refresh_ack, 1'b0);
			if (target == tgt_dram) begin
				check_value("cas_l", cas_l, 1'b0);
				check_value("ras_l", ras_l, 1'b0);
			end else if (target == tgt_rom) begin
				check_value("rom_cs_l", rom_cs_l, 1'b0);
			end else begin
				check_value("io_cs_l", io_cs_l, 1'b0);
			end
			if (write) begin
				exp_we = ~lane_mask(size, lo);
				check_value("we_l", we_l, exp_we);
				check_value("oe_l", oe_l, 1'b1);
			end else begin
				check_value("we_l", we_l, 4'hf);
				check_value("oe_l", oe_l, 1'b0);
			end
		end
	endtask

	// One whole transfer with req dropped the cycle after ack
	task automatic do_transfer(input int master, input logic write,
		input logic [`MEM_ADDR_W-1:0] addr, input mem_pkg::xfer_size_t size,
		input int target, input int exp_n, input int release_n);
		logic ok;
		@(posedge sys_clk);
		set_request(master, write, addr, size);
		wait_grant(master, ok);
		if (ok)
			wait_ack(target, exp_n, release_n, write, size, addr[1:0]);
		@(posedge sys_clk);
		drop_request(master);
	endtask

	task automatic dram_transfer(input logic write, input logic [`MEM_ADDR_W-1:0] addr,
		input mem_pkg::xfer_size_t size, input logic hit);
		int speed;
		speed = $urandom_range(3, 0);
		@(posedge sys_clk);
		dram_speed <= speed[1:0];
		do_transfer(0, write, addr, size, tgt_dram, dram_latency(hit, speed), -1);
		// Row phase only on a miss
		check_value("row_mux seen", row_seen, !hit);
		last_dram_addr = addr;
	endtask

	task automatic test_reset_state();
		@(negedge sys_clk);
		check_value("m0_gnt", m0_gnt, 1'b0);
		check_value("m1_gnt", m1_gnt, 1'b0);
		check_value("ack", ack, 1'b0);
		check_value("refresh_ack", refresh_ack, 1'b0);
		check_value("ras_l", ras_l, 1'b1);
		check_value("cas_l", cas_l, 1'b1);
		check_value("row_mux", row_mux, 1'b0);
		check_value("rom_cs_l", rom_cs_l, 1'b1);
		check_value("io_cs_l", io_cs_l, 1'b1);
		check_value("we_l", we_l, 4'hf);
		check_value("oe_l", oe_l, 1'b1);
	endtask

	task automatic test_rom_reads();
		logic [`MEM_ADDR_W-1:0] addr;
		for (int s = 0; s < 4; s++) begin
			addr = {2'b10, 22'($urandom)};
			@(posedge sys_clk);
			rom_speed <= s[1:0];
			do_transfer(0, 1'b0, addr, mem_pkg::size_word, tgt_rom, rom_wait(s) + 1, -1);
		end
	endtask

	task automatic test_dram_sequence();
		logic [`MEM_ADDR_W-1:0] addr;
		logic [`MEM_ADDR_W-1:0] other;
		// Bit 23 low, bit 22 random, both DRAM
		addr = {1'b0, 23'($urandom)};
		dram_transfer(1'b0, addr, mem_pkg::size_word, 1'b0);
		dram_transfer(1'b0, addr, mem_pkg::size_word, 1'b1);
		other = addr;
		other[`MEM_ROW_MSB:`MEM_ROW_LSB] = addr[`MEM_ROW_MSB:`MEM_ROW_LSB] ^
			12'($urandom_range(4095, 1));
		dram_transfer(1'b0, other, mem_pkg::size_word, 1'b0);
		// Writes stay in the open row
		dram_transfer(1'b1, {other[23:2], 2'($urandom)}, mem_pkg::size_byte, 1'b1);
		dram_transfer(1'b1, {other[23:2], 2'($urandom)}, mem_pkg::size_half, 1'b1);
		dram_transfer(1'b1, {other[23:2], 2'($urandom)}, mem_pkg::size_word, 1'b1);
	endtask

	task automatic test_io_waits();
		logic [`MEM_ADDR_W-1:0] addr;
		int k;
		for (int s = 0; s < 4; s++) begin
			addr = {2'b11, 22'($urandom)};
			@(posedge sys_clk);
			io_speed <= s[1:0];
			do_transfer(0, 1'b0, addr, mem_pkg::size_word, tgt_io, io_wait(s) + 1, -1);
			// External wait held over the expired count
			k = $urandom_range(6, 1);
			@(posedge sys_clk);
			io_wait_l <= 1'b0;
			do_transfer(0, 1'b1, addr, mem_pkg::size_half, tgt_io,
				io_wait(s) + 1 + k, io_wait(s) + k - 1);
		end
	endtask

	task automatic test_arbitration();
		logic [`MEM_ADDR_W-1:0] a0;
		logic [`MEM_ADDR_W-1:0] a1;
		logic ok;
		logic early;
		int speed;
		int n;
		a0 = {2'b10, 22'($urandom)};
		a1 = {2'b11, 22'($urandom)};
		// Both masters at once, m0 wins
		@(posedge sys_clk);
		set_request(0, 1'b0, a0, mem_pkg::size_word);
		set_request(1, 1'b0, a1, mem_pkg::size_half);
		wait_grant(0, ok);
		if (ok) begin
			check_value("m1_gnt", m1_gnt, 1'b0);
			wait_ack(tgt_rom, rom_wait(rom_speed) + 1, -1, 1'b0, mem_pkg::size_word, a0[1:0]);
		end
		@(posedge sys_clk);
		drop_request(0);
		wait_grant(1, ok);
		if (ok) begin
			check_value("m0_gnt", m0_gnt, 1'b0);
			wait_ack(tgt_io, io_wait(io_speed) + 1, -1, 1'b0, mem_pkg::size_half, a1[1:0]);
		end
		@(posedge sys_clk);
		drop_request(1);

		// Refresh against m0 on the row left open
		speed = $urandom_range(3, 0);
		@(posedge sys_clk);
		dram_speed <= speed[1:0];
		@(posedge sys_clk);
		refresh_req <= 1'b1;
		set_request(0, 1'b0, last_dram_addr, mem_pkg::size_word);
		// First falling edge is one cycle ahead of cycle 0
		n = -2;
		early = 1'b0;
		while (!refresh_ack && n < 40) begin
			@(negedge sys_clk);
			n++;
			if (m0_gnt || ack)
				early = 1'b1;
		end
		if (!refresh_ack) begin
			report_timeout("refresh_ack");
		end else begin
			check_value("refresh_ack latency", n, 2 * speed + 3);
			check_value("ack", ack, 1'b0);
		end
		if (early) begin
			errors++;
			$display("m0 was served before refresh_ack at %0t ns", $time);
		end
		@(posedge sys_clk);
		refresh_req <= 1'b0;
		wait_grant(0, ok);
		// Refresh closed the row, so this is a miss
		if (ok) begin
			wait_ack(tgt_dram, dram_latency(1'b0, speed), -1, 1'b0, mem_pkg::size_word,
				last_dram_addr[1:0]);
			check_value("row_mux seen", row_seen, 1'b1);
		end
		@(posedge sys_clk);
		drop_request(0);
	endtask

	initial begin
		void'($urandom(32'hb85f_221c));
		errors = 0;
		checks = 0;
		last_dram_addr = '0;
		row_seen = 1'b0;
		sys_clk = 1'b0;
		resetl = 1'b0;
		refresh_req = 1'b0;
		m0_req = 1'b0;
		m0_write = 1'b0;
		m0_addr = '0;
		m0_size = mem_pkg::size_byte;
		m1_req = 1'b0;
		m1_write = 1'b0;
		m1_addr = '0;
		m1_size = mem_pkg::size_byte;
		dram_speed = '0;
		rom_speed = '0;
		io_speed = '0;
		io_wait_l = 1'b1;
		repeat (4) @(posedge sys_clk);
		resetl <= 1'b1;

		test_reset_state();
		test_rom_reads();
		test_dram_sequence();
		test_io_waits();
		test_arbitration();

		repeat (4) @(posedge sys_clk);
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: verilog.f
+incdir+rtl
rtl/mem_pkg.sv
rtl/bus_arbiter.sv
rtl/cycle_sequencer.sv
rtl/dram_timing.sv
rtl/wait_counter.sv
rtl/byte_lanes.sv
rtl/mem_ctrl.sv
test/mem_ctrl_tb.sv
